//--- compile.f
verilog/ex_isa_pkg.sv
verilog/ex_stage_pkg.sv
verilog/ex_bitwise.sv
verilog/ex_arith.sv
verilog/ex_mul.sv
verilog/ex_hilo.sv
verilog/ex_stage.sv
dv/ex_stage_tb.sv

//--- dv/ex_stage_tb.sv
// Directed testbench for the execute stage
// Issues decoded requests, predicts each result with a small model and compares wb_o
// Top module is ex_stage_tb and is built through compile.f

module ex_stage_tb;
    timeunit 1ns;
    timeprecision 1ps;
    import ex_isa_pkg::*;
    import ex_stage_pkg::*;

    localparam int CLK_PERIOD  = 100;
    localparam int PLANNED_OPS = 91;
    // Up to three cycles per operation plus reset and idle cycles
    localparam int TIMEOUT_NS  = (PLANNED_OPS * 3 + 20) * CLK_PERIOD;

    logic    clk;
    logic    rst_i;
    logic    valid_i;
    ex_req_t req_i;
    logic    stall_o;
    logic    wb_valid_o;
    ex_wb_t  wb_o;

    logic [31:0] lfsr = 32'h69db;
    dword_t      ref_hilo = '0;
    int          issued = 0;
    int          value_errs = 0;
    int          ctrl_errs = 0;

    ex_stage i_ex_stage (
        .clk        (clk),
        .rst_i      (rst_i),
        .valid_i    (valid_i),
        .req_i      (req_i),
        .stall_o    (stall_o),
        .wb_valid_o (wb_valid_o),
        .wb_o       (wb_o)
    );

    initial begin
        clk = 1'b0;
        forever #(CLK_PERIOD / 2) clk = ~clk;
    end

    // Fibonacci LFSR with taps 32 22 2 1 stepped once per bit
    function automatic logic next_rand_bit();
        logic out;
        out  = lfsr[31];
        lfsr = {lfsr[30:0], lfsr[31] ^ lfsr[21] ^ lfsr[1] ^ lfsr[0]};
        return out;
    endfunction

    function automatic word_t rand_bits(input int n);
        word_t w;
        w = '0;
        for (int i = 0; i < n; i++) begin
            w = {w[30:0], next_rand_bit()};
        end
        return w;
    endfunction

    // Decode view of one instruction
    // Moves to HI/LO and multiplies write no register
    function automatic ex_req_t make_req(input aluop_e op, input word_t a, input word_t b);
        ex_req_t r;
        r.aluop = op;
        r.reg1  = a;
        r.reg2  = b;
        r.wd    = reg_addr_t'(issued + 1);
        r.wreg  = 1'b1;
        case (op)
            OP_OR, OP_AND, OP_NOR, OP_XOR: r.alusel = SEL_LOGIC;
            OP_SLL, OP_SRL, OP_SRA:        r.alusel = SEL_SHIFT;
            OP_MFHI, OP_MFLO:              r.alusel = SEL_MOVE;
            OP_MUL:                        r.alusel = SEL_MUL;
            OP_MTHI, OP_MTLO, OP_MULT, OP_MULTU, OP_MADD, OP_MADDU, OP_MSUB, OP_MSUBU: begin
                r.alusel = SEL_NOP;
                r.wreg   = 1'b0;
            end
            default:                       r.alusel = SEL_ARITH;
        endcase
        return r;
    endfunction

    // Reference model that also tracks HI/LO in program order
    function automatic ex_wb_t predict(input ex_req_t r);
        ex_wb_t e;
        word_t  a;
        word_t  b;
        word_t  res;
        longint sa;
        longint sb;
        longint sum;
        logic   ovf;
        int     n;
        a   = r.reg1;
        b   = r.reg2;
        sa  = longint'($signed(a));
        sb  = longint'($signed(b));
        sum = 0;
        res = '0;
        n   = 0;
        case (r.aluop)
            OP_OR:   res = a | b;
            OP_AND:  res = a & b;
            OP_NOR:  res = ~(a | b);
            OP_XOR:  res = a ^ b;
            OP_SLL:  res = b << a[4:0];
            OP_SRL:  res = b >> a[4:0];
            OP_SRA:  res = word_t'(sb >>> a[4:0]);
            OP_MFHI: res = ref_hilo[63:32];
            OP_MFLO: res = ref_hilo[31:0];
            OP_MTHI: ref_hilo[63:32] = a;
            OP_MTLO: ref_hilo[31:0] = a;
            OP_ADD, OP_ADDU, OP_ADDI, OP_ADDIU: sum = sa + sb;
            OP_SUB, OP_SUBU: sum = sa - sb;
            OP_SLT:  res = (sa < sb) ? 32'd1 : 32'd0;
            OP_SLTU: res = (a < b) ? 32'd1 : 32'd0;
            OP_CLZ, OP_CLO: begin
                while (n < 32 && a[31 - n] == (r.aluop == OP_CLO)) n++;
                res = word_t'(n);
            end
            OP_MUL:   res = word_t'(sa * sb);
            OP_MULT:  ref_hilo = dword_t'(sa * sb);
            OP_MULTU: ref_hilo = {32'd0, a} * {32'd0, b};
            OP_MADD:  ref_hilo = ref_hilo + dword_t'(sa * sb);
            OP_MADDU: ref_hilo = ref_hilo + {32'd0, a} * {32'd0, b};
            OP_MSUB:  ref_hilo = ref_hilo - dword_t'(sa * sb);
            OP_MSUBU: ref_hilo = ref_hilo - {32'd0, a} * {32'd0, b};
            default:  res = '0;
        endcase
        if (r.aluop inside {OP_ADD, OP_ADDU, OP_ADDI, OP_ADDIU, OP_SUB, OP_SUBU}) begin
            res = sum[31:0];
        end
        // A true sum that differs from its sign-extended low word has overflowed
        ovf     = sum != longint'($signed(sum[31:0]));
        e.wd    = r.wd;
        e.wreg  = r.wreg && !(ovf && r.aluop inside {OP_ADD, OP_ADDI, OP_SUB});
        e.wdata = res;
        return e;
    endfunction

    task automatic check_wb(input string name, input ex_wb_t exp, input ex_wb_t act);
        if (act !== exp) begin
            value_errs++;
            $display("ERR %s: expected wd=%0d wreg=%b wdata=%h, actual wd=%0d wreg=%b wdata=%h",
                     name, exp.wd, exp.wreg, exp.wdata, act.wd, act.wreg, act.wdata);
        end
    endtask

    task automatic check_word(input string name, input word_t exp, input word_t act);
        if (act !== exp) begin
            value_errs++;
            $display("ERR %s: expected %h, actual %h", name, exp, act);
        end
    endtask

    task automatic check_bit(input string name, input logic exp, input logic act);
        if (act !== exp) begin
            ctrl_errs++;
            $display("ERR %s: expected %b, actual %b", name, exp, act);
        end
    endtask

    // Starts just after a rising edge and returns just after the accepting edge
    task automatic issue(input ex_req_t r, output int stalls);
        stalls = 0;
        valid_i <= 1'b1;
        req_i   <= r;
        @(negedge clk);
        while (stall_o) begin
            stalls++;
            @(posedge clk);
            @(negedge clk);
            // Nothing is accepted while the request stalls
            check_bit("stall wb_valid", 1'b0, wb_valid_o);
        end
        @(posedge clk);
        issued++;
    endtask

    task automatic run_op(input string name, input aluop_e op, input word_t a, input word_t b);
        ex_req_t r;
        ex_wb_t  exp;
        int      stalls;
        int      exp_stalls;
        r          = make_req(op, a, b);
        exp        = predict(r);
        exp_stalls = (op inside {OP_MADD, OP_MADDU, OP_MSUB, OP_MSUBU}) ? 1 : 0;
        issue(r, stalls);
        valid_i <= 1'b0;
        @(negedge clk);
        check_word({name, " stall cycles"}, word_t'(exp_stalls), word_t'(stalls));
        check_bit({name, " wb_valid"}, 1'b1, wb_valid_o);
        check_wb(name, exp, wb_o);
        @(posedge clk);
    endtask

    task automatic test_reset();
        @(negedge clk);
        check_bit("reset wb_valid", 1'b0, wb_valid_o);
        check_bit("reset stall", 1'b0, stall_o);
        check_bit("reset wreg", 1'b0, wb_o.wreg);
        @(posedge clk);
        run_op("MFHI after reset", OP_MFHI, '0, '0);
        run_op("MFLO after reset", OP_MFLO, '0, '0);
    endtask

    task automatic test_logic();
        aluop_e ops[7] = '{OP_OR, OP_AND, OP_NOR, OP_XOR, OP_SLL, OP_SRL, OP_SRA};
        for (int k = 0; k < 3; k++) begin
            for (int i = 0; i < 7; i++) begin
                run_op(ops[i].name(), ops[i], rand_bits(32), rand_bits(32));
            end
        end
        // Upper byte fills with ones
        run_op("SRA negative", OP_SRA, 32'd8, 32'h8000_1234 | rand_bits(16));
    endtask

    task automatic test_arith();
        aluop_e ops[4] = '{OP_ADD, OP_ADDU, OP_SUB, OP_SUBU};
        for (int k = 0; k < 2; k++) begin
            for (int i = 0; i < 4; i++) begin
                run_op(ops[i].name(), ops[i], rand_bits(32), rand_bits(32));
            end
        end
        run_op("ADD overflow", OP_ADD, 32'h7fff_ffff, 32'h0000_0001);
        run_op("ADDI overflow", OP_ADDI, 32'h8000_0000, 32'hffff_ffff);
        run_op("SUB overflow", OP_SUB, 32'h8000_0000, 32'h0000_0001);
        run_op("ADDU wrap", OP_ADDU, 32'h7fff_ffff, 32'h0000_0001);
        run_op("ADDIU", OP_ADDIU, rand_bits(32), rand_bits(32));
        run_op("SLT neg", OP_SLT, 32'hffff_ffff, 32'h0000_0001);
        run_op("SLTU neg", OP_SLTU, 32'hffff_ffff, 32'h0000_0001);
        run_op("SLT pos", OP_SLT, 32'h0000_0001, 32'hffff_ffff);
        run_op("SLTU pos", OP_SLTU, 32'h0000_0001, 32'hffff_ffff);
        for (int k = 0; k < 2; k++) begin
            run_op("SLT random", OP_SLT, rand_bits(32), rand_bits(32));
            run_op("SLTU random", OP_SLTU, rand_bits(32), rand_bits(32));
        end
        run_op("CLZ zero", OP_CLZ, 32'h0000_0000, '0);
        run_op("CLZ ones", OP_CLZ, 32'hffff_ffff, '0);
        run_op("CLO ones", OP_CLO, 32'hffff_ffff, '0);
        run_op("CLO zero", OP_CLO, 32'h0000_0000, '0);
        for (int k = 0; k < 3; k++) begin
            run_op("CLZ random", OP_CLZ, rand_bits(32) >> rand_bits(5), '0);
            run_op("CLO random", OP_CLO, ~(rand_bits(32) >> rand_bits(5)), '0);
        end
    endtask

    task automatic test_mul();
        run_op("MUL negative", OP_MUL, rand_bits(32) | 32'h8000_0000, rand_bits(32));
        run_op("MUL random", OP_MUL, rand_bits(32), rand_bits(32));
        run_op("MULT", OP_MULT, rand_bits(32) | 32'h8000_0000, rand_bits(31));
        run_op("MFHI after MULT", OP_MFHI, '0, '0);
        run_op("MFLO after MULT", OP_MFLO, '0, '0);
        run_op("MULTU", OP_MULTU, 32'hffff_ffff, rand_bits(32) | 32'h8000_0000);
        run_op("MFHI after MULTU", OP_MFHI, '0, '0);
        run_op("MFLO after MULTU", OP_MFLO, '0, '0);
    endtask

    task automatic test_acc();
        aluop_e ops[4] = '{OP_MADD, OP_MADDU, OP_MSUB, OP_MSUBU};
        for (int i = 0; i < 4; i++) begin
            run_op("MTHI", OP_MTHI, 32'h0000_1234 + word_t'(i), '0);
            run_op("MTLO", OP_MTLO, 32'hfedc_ba98, '0);
            run_op(ops[i].name(), ops[i], rand_bits(32) | 32'h8000_0000, rand_bits(32));
            run_op("MFHI after accumulate", OP_MFHI, '0, '0);
            run_op("MFLO after accumulate", OP_MFLO, '0, '0);
        end
    endtask

    // One request per cycle with result i checked while request i+1 is presented
    task automatic test_back_to_back();
        ex_req_t reqs[8];
        ex_wb_t  exps[8];
        word_t   new_hi;
        new_hi  = rand_bits(32);
        reqs[0] = make_req(OP_OR, rand_bits(32), rand_bits(32));
        reqs[1] = make_req(OP_XOR, rand_bits(32), rand_bits(32));
        reqs[2] = make_req(OP_SLL, rand_bits(32), rand_bits(32));
        reqs[3] = make_req(OP_ADDU, rand_bits(32), rand_bits(32));
        reqs[4] = make_req(OP_SLTU, rand_bits(32), rand_bits(32));
        reqs[5] = make_req(OP_NOR, rand_bits(32), rand_bits(32));
        reqs[6] = make_req(OP_MTHI, new_hi, '0);
        reqs[7] = make_req(OP_MFHI, '0, '0);
        for (int i = 0; i < 8; i++) begin
            reqs[i].wd = reg_addr_t'(i + 10);
            exps[i]    = predict(reqs[i]);
        end
        for (int i = 0; i < 8; i++) begin
            valid_i <= 1'b1;
            req_i   <= reqs[i];
            @(negedge clk);
            check_bit("back-to-back stall", 1'b0, stall_o);
            if (i > 0) begin
                check_bit("back-to-back wb_valid", 1'b1, wb_valid_o);
                check_wb($sformatf("back-to-back %0d", i - 1), exps[i - 1], wb_o);
            end
            @(posedge clk);
            issued++;
        end
        valid_i <= 1'b0;
        @(negedge clk);
        check_bit("back-to-back wb_valid", 1'b1, wb_valid_o);
        check_wb("MFHI after MTHI", exps[7], wb_o);
        check_word("MFHI sees new HI", new_hi, wb_o.wdata);
        @(posedge clk);
        @(negedge clk);
        check_bit("idle wb_valid", 1'b0, wb_valid_o);
        @(posedge clk);
    endtask

    initial begin
        rst_i   <= 1'b1;
        valid_i <= 1'b0;
        req_i   <= '0;
        repeat (2) @(posedge clk);
        rst_i <= 1'b0;
        test_reset();
        test_logic();
        test_arith();
        test_mul();
        test_acc();
        test_back_to_back();
        $display("Done: %0d operations, %0d value errors, %0d control errors",
                 issued, value_errs, ctrl_errs);
        if (value_errs == 0 && ctrl_errs == 0) begin
            $display("STATUS: PASS");
        end else begin
            $display("STATUS: FAIL");
        end
        $finish;
    end

    initial begin
        #(TIMEOUT_NS);
        $display("Timeout: tests still running after %0d ns", TIMEOUT_NS);
        $display("STATUS: FAIL");
        $finish;
    end

endmodule

//--- run_sim.sh
#!/bin/sh
# Build the execute-stage testbench with Verilator and run it
cd "$(dirname "$0")" || exit 1

verilator --binary --timing --timescale 1ns/1ps -f compile.f \
    --top-module ex_stage_tb -Mdir obj_dir -o ex_stage_sim
if [ $? -ne 0 ]; then
    echo "Verilator build failed"
    exit 1
fi

output=$(./obj_dir/ex_stage_sim)
status=$?
printf '%s\n' "$output"
if [ $status -ne 0 ]; then
    echo "Simulation exited with status $status"
    exit 1
fi

if printf '%s\n' "$output" | grep -q '^STATUS: PASS$'; then
    exit 0
fi
exit 1

//--- verilog/ex_arith.sv
// Arithmetic unit of the execute stage
// One shared adder serves add, subtract and signed compare
// Also counts leading zeros and ones, and reports signed overflow

module ex_arith (
    input  ex_isa_pkg::aluop_e aluop_i,
    input  ex_isa_pkg::word_t  reg1_i,
    input  ex_isa_pkg::word_t  reg2_i,
    output ex_isa_pkg::word_t  arith_o,
    output logic               overflow_o
);
    import ex_isa_pkg::*;

    logic  do_sub;
    word_t reg2_mux;
    word_t sum;
    logic  lt_signed;
    logic  lt_unsigned;

    // Number of leading bits equal to val, 0 to 32
    function automatic logic [5:0] lead_count(input word_t w, input logic val);
        logic [5:0] cnt;
        logic       done;
        cnt  = '0;
        done = 1'b0;
        for (int i = XLEN - 1; i >= 0; i--) begin
            if (!done) begin
                if (w[i] == val) begin
                    cnt = cnt + 1'b1;
                end else begin
                    done = 1'b1;
                end
            end
        end
        return cnt;
    endfunction

    assign do_sub   = aluop_i inside {OP_SUB, OP_SUBU, OP_SLT};
    assign reg2_mux = do_sub ? (~reg2_i + 1'b1) : reg2_i;
    assign sum      = reg1_i + reg2_mux;

    // Same-sign operands whose sum flips sign
    assign overflow_o = (reg1_i[XLEN-1] == reg2_mux[XLEN-1]) &&
                        (sum[XLEN-1] != reg1_i[XLEN-1]);

    // Negative beats positive; equal signs look at the difference
    assign lt_signed = (reg1_i[XLEN-1] && !reg2_i[XLEN-1]) ||
                       ((reg1_i[XLEN-1] == reg2_i[XLEN-1]) && sum[XLEN-1]);
    assign lt_unsigned = reg1_i < reg2_i;

    always_comb begin
        case (aluop_i)
            OP_ADD, OP_ADDU, OP_ADDI, OP_ADDIU, OP_SUB, OP_SUBU: begin
                arith_o = sum;
            end
            OP_SLT: begin
                arith_o = word_t'(lt_signed);
            end
            OP_SLTU: begin
                arith_o = word_t'(lt_unsigned);
            end
            OP_CLZ: begin
                arith_o = word_t'(lead_count(reg1_i, 1'b0));
            end
            OP_CLO: begin
                arith_o = word_t'(lead_count(reg1_i, 1'b1));
            end
            default: begin
                arith_o = '0;
            end
        endcase
    end

endmodule

//--- verilog/ex_bitwise.sv
// Logic and shift unit of the execute stage
// Purely combinational, gives zero for operations it does not own
// Shift amount comes from the low bits of reg1, the shifted value is reg2

module ex_bitwise (
    input  ex_isa_pkg::aluop_e aluop_i,
    input  ex_isa_pkg::word_t  reg1_i,
    input  ex_isa_pkg::word_t  reg2_i,
    output ex_isa_pkg::word_t  logic_o,
    output ex_isa_pkg::word_t  shift_o
);
    import ex_isa_pkg::*;

    logic [SHAMT_W-1:0] shamt;

    assign shamt = reg1_i[SHAMT_W-1:0];

    always_comb begin
        case (aluop_i)
            OP_OR: begin
                logic_o = reg1_i | reg2_i;
            end
            OP_AND: begin
                logic_o = reg1_i & reg2_i;
            end
            OP_NOR: begin
                logic_o = ~(reg1_i | reg2_i);
            end
            OP_XOR: begin
                logic_o = reg1_i ^ reg2_i;
            end
            default: begin
                logic_o = '0;
            end
        endcase
    end

    always_comb begin
        case (aluop_i)
            OP_SLL: begin
                shift_o = reg2_i << shamt;
            end
            OP_SRL: begin
                shift_o = reg2_i >> shamt;
            end
            // Arithmetic shift keeps the sign of reg2
            OP_SRA: begin
                shift_o = word_t'($signed(reg2_i) >>> shamt);
            end
            default: begin
                shift_o = '0;
            end
        endcase
    end

endmodule

//--- verilog/ex_hilo.sv
// HI/LO register of the execute stage
// Written on accepted instructions, multiply results win over moves
// MTHI and MTLO replace one half and keep the other

module ex_hilo (
    input  logic                clk,
    input  logic                rst_i,
    input  logic                en_i,
    input  ex_isa_pkg::aluop_e  aluop_i,
    input  ex_isa_pkg::word_t   reg1_i,
    input  logic                mul_we_i,
    input  ex_stage_pkg::hilo_u mul_hilo_i,
    output ex_stage_pkg::hilo_u hilo_o
);
    import ex_isa_pkg::*;
    import ex_stage_pkg::*;

    hilo_u hilo_q;
    hilo_u hilo_d;
    logic  write;

    always_comb begin
        hilo_d = hilo_q;
        write  = 1'b0;
        if (mul_we_i) begin
            hilo_d = mul_hilo_i;
            write  = 1'b1;
        end else begin
            case (aluop_i)
                OP_MTHI: begin
                    hilo_d.half.hi = reg1_i;
                    write          = 1'b1;
                end
                OP_MTLO: begin
                    hilo_d.half.lo = reg1_i;
                    write          = 1'b1;
                end
                default: begin
                    write = 1'b0;
                end
            endcase
        end
    end

    always_ff @(posedge clk) begin
        if (rst_i) begin
            hilo_q <= '0;
        end else if (en_i && write) begin
            hilo_q <= hilo_d;
        end
    end

    assign hilo_o = hilo_q;

endmodule

//--- verilog/ex_isa_pkg.sv
// ISA-level definitions for the execute stage
// Word widths, operation codes and result-group codes as decoded upstream
// Imported by every execute-stage module that needs them

package ex_isa_pkg;

    localparam int XLEN       = 32;
    localparam int SHAMT_W    = 5;
    localparam int REG_ADDR_W = 5;

    typedef logic [XLEN-1:0]       word_t;
    typedef logic [2*XLEN-1:0]     dword_t;
    typedef logic [REG_ADDR_W-1:0] reg_addr_t;

    // Operation codes as produced by the decode stage
    typedef enum logic [7:0] {
        OP_NOP   = 8'b0000_0000,
        OP_AND   = 8'b0010_0100,
        OP_OR    = 8'b0010_0101,
        OP_XOR   = 8'b0010_0110,
        OP_NOR   = 8'b0010_0111,
        OP_SLL   = 8'b0111_1100,
        OP_SRL   = 8'b0000_0010,
        OP_SRA   = 8'b0000_0011,
        OP_MFHI  = 8'b0001_0000,
        OP_MTHI  = 8'b0001_0001,
        OP_MFLO  = 8'b0001_0010,
        OP_MTLO  = 8'b0001_0011,
        OP_SLT   = 8'b0010_1010,
        OP_SLTU  = 8'b0010_1011,
        OP_ADD   = 8'b0010_0000,
        OP_ADDU  = 8'b0010_0001,
        OP_SUB   = 8'b0010_0010,
        OP_SUBU  = 8'b0010_0011,
        OP_ADDI  = 8'b0101_0101,
        OP_ADDIU = 8'b0101_0110,
        OP_CLZ   = 8'b1011_0000,
        OP_CLO   = 8'b1011_0001,
        OP_MULT  = 8'b0001_1000,
        OP_MULTU = 8'b0001_1001,
        OP_MUL   = 8'b1010_1001,
        OP_MADD  = 8'b1010_0110,
        OP_MADDU = 8'b1010_1000,
        OP_MSUB  = 8'b1010_1010,
        OP_MSUBU = 8'b1010_1011
    } aluop_e;

    // Result group that feeds the write-back word
    typedef enum logic [2:0] {
        SEL_NOP   = 3'b000,
        SEL_LOGIC = 3'b001,
        SEL_SHIFT = 3'b010,
        SEL_MOVE  = 3'b011,
        SEL_ARITH = 3'b100,
        SEL_MUL   = 3'b101
    } alusel_e;

endpackage

//--- verilog/ex_mul.sv
// Multiply unit with the two-cycle multiply-accumulate sequencer
// First accumulate cycle stalls and stores the product, second adds HI/LO
// Requests HI/LO writes for MULT, MULTU and the accumulate family

module ex_mul (
    input  logic                clk,
    input  logic                rst_i,
    input  logic                valid_i,
    input  ex_isa_pkg::aluop_e  aluop_i,
    input  ex_isa_pkg::word_t   reg1_i,
    input  ex_isa_pkg::word_t   reg2_i,
    input  ex_stage_pkg::hilo_u hilo_i,
    output logic                stall_o,
    output ex_isa_pkg::word_t   mul_lo_o,
    output logic                hilo_we_o,
    output ex_stage_pkg::hilo_u hilo_wdata_o
);
    import ex_isa_pkg::*;

    logic   is_signed;
    logic   is_acc;
    logic   is_sub;
    logic   phase_q;
    word_t  op1;
    word_t  op2;
    dword_t prod_mag;
    dword_t prod;
    dword_t acc_q;

    assign is_signed = aluop_i inside {OP_MUL, OP_MULT, OP_MADD, OP_MSUB};
    assign is_acc    = aluop_i inside {OP_MADD, OP_MADDU, OP_MSUB, OP_MSUBU};
    assign is_sub    = aluop_i inside {OP_MSUB, OP_MSUBU};

    // Signed forms multiply magnitudes and fix the sign afterwards
    assign op1      = (is_signed && reg1_i[XLEN-1]) ? -reg1_i : reg1_i;
    assign op2      = (is_signed && reg2_i[XLEN-1]) ? -reg2_i : reg2_i;
    assign prod_mag = dword_t'(op1) * dword_t'(op2);
    assign prod     = (is_signed && (reg1_i[XLEN-1] ^ reg2_i[XLEN-1])) ? -prod_mag : prod_mag;
    assign mul_lo_o = prod[XLEN-1:0];

    // Stall only in the first accumulate cycle
    assign stall_o = is_acc && !phase_q;

    always_ff @(posedge clk) begin
        if (rst_i) begin
            phase_q <= 1'b0;
        end else if (phase_q && valid_i) begin
            phase_q <= 1'b0;
        end else if (!phase_q && valid_i && is_acc) begin
            phase_q <= 1'b1;
        end
    end

    // Held product, negated for the subtracting forms
    always_ff @(posedge clk) begin
        if (valid_i && is_acc && !phase_q) begin
            acc_q <= is_sub ? -prod : prod;
        end
    end

    always_comb begin
        hilo_we_o          = 1'b0;
        hilo_wdata_o.dword = prod;
        if (aluop_i inside {OP_MULT, OP_MULTU}) begin
            hilo_we_o = 1'b1;
        end else if (is_acc && phase_q) begin
            hilo_we_o          = 1'b1;
            hilo_wdata_o.dword = acc_q + hilo_i.dword;
        end
    end

endmodule

//--- verilog/ex_stage.sv
// Execute stage top level
// Takes one decoded request per cycle when not stalled
// Result and HI/LO update land on the same edge, one cycle after accept
// Multiply-accumulates stall for one extra cycle

module ex_stage (
    input  logic                  clk,
    input  logic                  rst_i,
    input  logic                  valid_i,
    input  ex_stage_pkg::ex_req_t req_i,
    output logic                  stall_o,
    output logic                  wb_valid_o,
    output ex_stage_pkg::ex_wb_t  wb_o
);
    import ex_isa_pkg::*;
    import ex_stage_pkg::*;

    logic   accept;
    word_t  logic_res;
    word_t  shift_res;
    word_t  arith_res;
    word_t  move_res;
    word_t  mul_lo;
    logic   overflow;
    logic   ovf_cancel;
    logic   hilo_we;
    hilo_u  hilo_wdata;
    hilo_u  hilo;
    ex_wb_t wb_d;

    assign accept = valid_i && !stall_o;

    ex_bitwise i_ex_bitwise (
        .aluop_i (req_i.aluop),
        .reg1_i  (req_i.reg1),
        .reg2_i  (req_i.reg2),
        .logic_o (logic_res),
        .shift_o (shift_res)
    );

    ex_arith i_ex_arith (
        .aluop_i    (req_i.aluop),
        .reg1_i     (req_i.reg1),
        .reg2_i     (req_i.reg2),
        .arith_o    (arith_res),
        .overflow_o (overflow)
    );

    ex_mul i_ex_mul (
        .clk          (clk),
        .rst_i        (rst_i),
        .valid_i      (valid_i),
        .aluop_i      (req_i.aluop),
        .reg1_i       (req_i.reg1),
        .reg2_i       (req_i.reg2),
        .hilo_i       (hilo),
        .stall_o      (stall_o),
        .mul_lo_o     (mul_lo),
        .hilo_we_o    (hilo_we),
        .hilo_wdata_o (hilo_wdata)
    );

    ex_hilo i_ex_hilo (
        .clk        (clk),
        .rst_i      (rst_i),
        .en_i       (accept),
        .aluop_i    (req_i.aluop),
        .reg1_i     (req_i.reg1),
        .mul_we_i   (hilo_we),
        .mul_hilo_i (hilo_wdata),
        .hilo_o     (hilo)
    );

    assign move_res = (req_i.aluop == OP_MFHI) ? hilo.half.hi :
                      (req_i.aluop == OP_MFLO) ? hilo.half.lo : '0;

    // Trapping adds and subtracts drop their register write on overflow
    assign ovf_cancel = overflow && (req_i.aluop inside {OP_ADD, OP_ADDI, OP_SUB});

    always_comb begin
        wb_d.wd   = req_i.wd;
        wb_d.wreg = req_i.wreg && !ovf_cancel;
        case (req_i.alusel)
            SEL_LOGIC: wb_d.wdata = logic_res;
            SEL_SHIFT: wb_d.wdata = shift_res;
            SEL_MOVE:  wb_d.wdata = move_res;
            SEL_ARITH: wb_d.wdata = arith_res;
            SEL_MUL:   wb_d.wdata = mul_lo;
            default:   wb_d.wdata = '0;
        endcase
    end

    always_ff @(posedge clk) begin
        if (rst_i) begin
            wb_valid_o <= 1'b0;
            wb_o.wreg  <= 1'b0;
        end else begin
            wb_valid_o <= accept;
            if (accept) begin
                wb_o <= wb_d;
            end
        end
    end

endmodule

//--- verilog/ex_stage_pkg.sv
// Structured signals of the execute stage
// Request and write-back bundles plus the HI/LO register view
// Port types use these through scoped names

package ex_stage_pkg;

    import ex_isa_pkg::*;

    // One decoded instruction handed over by decode
    typedef struct packed {
        aluop_e    aluop;
        alusel_e   alusel;
        word_t     reg1;
        word_t     reg2;
        reg_addr_t wd;
        logic      wreg;
    } ex_req_t;

    // Register-file write request toward the memory stage
    typedef struct packed {
        reg_addr_t wd;
        logic      wreg;
        word_t     wdata;
    } ex_wb_t;

    // HI in the upper word, LO in the lower word
    typedef struct packed {
        word_t hi;
        word_t lo;
    } hilo_half_t;

    // Seen as one 64-bit value for products and accumulation
    // and as two halves for the move instructions
    typedef union packed {
        dword_t     dword;
        hilo_half_t half;
    } hilo_u;

endpackage
